//--- test/muldiv_input.txt
# funct src1 src2 expected_hi expected_lo illegal (all hex)
# divides give the remainder in hi and the quotient in lo
18 00000003 00000005 00000000 0000000f 0
18 fffffffd 00000005 ffffffff fffffff1 0
18 ffffffff ffffffff 00000000 00000001 0
19 ffffffff ffffffff fffffffe 00000001 0
18 80000000 80000000 40000000 00000000 0
19 00010000 00010000 00000001 00000000 0
18 7fffffff fffffffe ffffffff 00000002 0
19 ffffffff 00000002 00000001 fffffffe 0
18 0000abcd 00001234 00000000 0c374fa4 0
1a 00000007 00000002 00000001 00000003 0
1a fffffff9 00000002 ffffffff fffffffd 0
1a 00000007 fffffffe 00000001 fffffffd 0
1a fffffff9 fffffffe ffffffff 00000003 0
1a 80000000 ffffffff 00000000 80000000 0
1a 00000005 00000000 00000005 ffffffff 0
1a fffffffb 00000000 fffffffb 00000001 0
1b ffffffff 00000000 ffffffff ffffffff 0
1b ffffffff 00000010 0000000f 0fffffff 0
1b 80000000 ffffffff 80000000 00000000 0
1b 12345678 00001000 00000678 00012345 0
1a 00000064 fffffff9 00000002 fffffff2 0
20 00000011 00000022 00000000 00000000 1
10 12345678 9abcdef0 00000000 00000000 1
19 00010000 00010000 00000001 00000000 0

//--- muldiv.f
+incdir+include
source/md_op_pkg.sv
source/md_ctrl_pkg.sv
source/md_issue.sv
source/md_multiplier.sv
source/md_divider.sv
source/md_result.sv
source/muldiv_unit.sv
test/muldiv_clk_gen.sv
test/muldiv_props.sv
test/muldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the muldiv testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module muldiv_tb -f muldiv.f -o muldiv_sim

./obj_dir/muldiv_sim | tee "$LOG"

if grep -qx "test passed" "$LOG"; then
    echo "simulation result: PASS"
    exit 0
else
    echo "simulation result: FAIL"
    exit 1
fi

//--- test/muldiv_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_tb;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic [5:0]        funct;
    logic [`XLEN-1:0]  src1;
    logic [`XLEN-1:0]  src2;
    logic              out_ready;
    logic              busy;
    logic              out_valid;
    logic [`XLEN-1:0]  hi;
    logic [`XLEN-1:0]  lo;

    logic [5:0]        vec_funct [$];
    logic [`XLEN-1:0]  vec_src1 [$];
    logic [`XLEN-1:0]  vec_src2 [$];
    logic [`XLEN-1:0]  vec_hi [$];
    logic [`XLEN-1:0]  vec_lo [$];
    logic              vec_illegal [$];
    logic              vec_loaded = 1'b0;
    logic [31:0]       lfsr_state = 32'h64b5d2c0;
    int                error_count = 0;

    muldiv_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    muldiv_unit i_muldiv_unit (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .funct     (funct),
        .src1      (src1),
        .src2      (src2),
        .out_ready (out_ready),
        .busy      (busy),
        .out_valid (out_valid),
        .hi        (hi),
        .lo        (lo)
    );

    // Galois LFSR stepped once per bit taken
    task automatic draw_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003)
                                       : (lfsr_state >> 1);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    // entered right after a rising edge, leaves right after the retire edge
    task automatic run_vector(input int idx, output logic ok);
        logic [7:0]        pick;
        logic [7:0]        stall;
        logic              got;
        int                waited;
        int                errs_before;
        errs_before = error_count;
        in_valid <= 1'b1;
        funct    <= vec_funct[idx];
        src1     <= vec_src1[idx];
        src2     <= vec_src2[idx];
        @(negedge clk);
        check_value("busy", 32'd0, busy);
        check_value("out_valid", 32'd0, out_valid);
        @(posedge clk);
        in_valid <= 1'b0;
        if (vec_illegal[idx]) begin
            repeat (50) begin
                @(negedge clk);
                check_value("out_valid", 32'd0, out_valid);
                check_value("busy", 32'd0, busy);
            end
            @(posedge clk);
        end else begin
            got = 1'b0;
            waited = 0;
            while (!got && waited < 60) begin
                @(negedge clk);
                got = out_valid;
                waited++;
                if (!got) begin
                    check_value("busy", 32'd1, busy);
                    // stray strobes while busy must be dropped
                    @(posedge clk);
                    draw_bits(3, pick);
                    in_valid <= pick[2];
                    funct    <= `FUNCT_MULT | {4'b0000, pick[1:0]};
                    src1     <= ~vec_src1[idx];
                end
            end
            if (!got) begin
                $display("test %0d: out_valid did not rise within 60 cycles", idx);
                error_count++;
                @(posedge clk);
                in_valid <= 1'b0;
            end else begin
                check_value("hi", vec_hi[idx], hi);
                check_value("lo", vec_lo[idx], lo);
                draw_bits(3, stall);
                repeat (stall) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                    @(negedge clk);
                    check_value("out_valid", 32'd1, out_valid);
                    check_value("busy", 32'd1, busy);
                    check_value("hi", vec_hi[idx], hi);
                    check_value("lo", vec_lo[idx], lo);
                end
                @(posedge clk);
                in_valid  <= 1'b0;
                out_ready <= 1'b1;
                @(posedge clk);
                out_ready <= 1'b0;
            end
        end
        ok = (error_count == errs_before);
        $display("test %0d funct %h: %s", idx, vec_funct[idx], ok ? "ok" : "mismatch");
    endtask

    initial begin
        int           fd;
        int           nread;
        int           n_ok;
        string        line;
        logic [5:0]   f;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  h;
        logic [31:0]  l;
        logic         ill;
        logic         ok;
        in_valid  = 1'b0;
        funct     = '0;
        src1      = '0;
        src2      = '0;
        out_ready = 1'b0;
        n_ok      = 0;
        fd = $fopen("test/muldiv_input.txt", "r");
        if (fd == 0) begin
            $display("could not open test/muldiv_input.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                nread = $sscanf(line, "%h %h %h %h %h %h", f, a, b, h, l, ill);
                if (nread == 6) begin
                    vec_funct.push_back(f);
                    vec_src1.push_back(a);
                    vec_src2.push_back(b);
                    vec_hi.push_back(h);
                    vec_lo.push_back(l);
                    vec_illegal.push_back(ill);
                end
            end
            $fclose(fd);
        end
        vec_loaded = 1'b1;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        for (int i = 0; i < vec_funct.size(); i++) begin
            run_vector(i, ok);
            if (ok) begin
                n_ok++;
            end
        end
        // last result must be gone and the unit idle
        @(negedge clk);
        check_value("out_valid", 32'd0, out_valid);
        check_value("busy", 32'd0, busy);
        $display("%0d vectors run, %0d ok, %0d errors", vec_funct.size(), n_ok, error_count);
        if (error_count == 0 && vec_funct.size() > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog sized from the vector count
    initial begin
        int limit;
        wait (vec_loaded);
        limit = vec_funct.size() * 60 + 200;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run hung", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/muldiv_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_props (
    input wire logic              clk,
    input wire logic              rst,
    input wire logic              in_valid,
    input wire logic [5:0]        funct,
    input wire logic              busy,
    input wire logic              mul_start,
    input wire logic              div_start,
    input wire logic              out_valid,
    input wire logic              out_ready,
    input wire logic [`XLEN-1:0]  hi,
    input wire logic [`XLEN-1:0]  lo
);

    logic mul_accept;

    // a multiply strobe that the issue block takes
    assign mul_accept = in_valid && !busy &&
                        (funct == `FUNCT_MULT || funct == `FUNCT_MULTU);

    start_while_busy: assert property (@(posedge clk) disable iff (rst)
        busy |=> !(mul_start || div_start))
        else $error("start pulse issued while an operation was outstanding");

    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(hi) && $stable(lo))
        else $error("result changed while out_ready was low");

    idle_after_reset: assert property (@(posedge clk)
        rst |=> !out_valid && !busy)
        else $error("out_valid or busy high right after reset");

    // result register is empty one cycle before the product lands
    mul_not_early: assert property (@(posedge clk) disable iff (rst)
        $past(mul_accept, 3) |-> !out_valid)
        else $error("multiply result appeared too early");

    mul_latency: assert property (@(posedge clk) disable iff (rst)
        $past(mul_accept, 4) |-> out_valid)
        else $error("multiply result missing four cycles after acceptance");

endmodule

bind muldiv_unit muldiv_props u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .funct     (funct),
    .busy      (busy),
    .mul_start (mul_start),
    .div_start (div_start),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .hi        (hi),
    .lo        (lo)
);

`default_nettype wire

//--- test/muldiv_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module muldiv_clk_gen (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held over the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- source/muldiv_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module muldiv_unit (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              in_valid,
    input  wire logic [5:0]        funct,
    input  wire logic [`XLEN-1:0]  src1,
    input  wire logic [`XLEN-1:0]  src2,
    input  wire logic              out_ready,
    output logic                   busy,
    output logic                   out_valid,
    output logic [`XLEN-1:0]       hi,
    output logic [`XLEN-1:0]       lo
);

    logic                   mul_start;
    logic                   div_start;
    logic                   mul_done;
    logic                   div_done;
    logic                   retire;
    md_op_pkg::md_req_t     req;
    md_op_pkg::md_res_t     mul_res;
    md_op_pkg::md_res_t     div_res;
    md_ctrl_pkg::md_src_e   src;

    md_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .funct     (funct),
        .src1      (src1),
        .src2      (src2),
        .retire    (retire),
        .busy      (busy),
        .mul_start (mul_start),
        .div_start (div_start),
        .req       (req),
        .src       (src)
    );

    md_multiplier u_multiplier (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .req   (req),
        .done  (mul_done),
        .res   (mul_res)
    );

    md_divider u_divider (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .req   (req),
        .done  (div_done),
        .res   (div_res)
    );

    md_result u_result (
        .clk       (clk),
        .rst       (rst),
        .src       (src),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .mul_res   (mul_res),
        .div_res   (div_res),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .hi        (hi),
        .lo        (lo),
        .retire    (retire)
    );

endmodule

`default_nettype wire

//--- source/md_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module md_result (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire md_ctrl_pkg::md_src_e  src,
    input  wire logic                  mul_done,
    input  wire logic                  div_done,
    input  wire md_op_pkg::md_res_t    mul_res,
    input  wire md_op_pkg::md_res_t    div_res,
    input  wire logic                  out_ready,
    output logic                       out_valid,
    output logic [`XLEN-1:0]           hi,
    output logic [`XLEN-1:0]           lo,
    output logic                       retire
);

    logic                  capture;
    md_op_pkg::md_res_t    sel_res;
    md_op_pkg::md_res_t    res_q;

    // only the unit that owns the pending operation is listened to
    assign capture = (src == md_ctrl_pkg::SRC_MUL) ? mul_done : div_done;
    assign sel_res = (src == md_ctrl_pkg::SRC_MUL) ? mul_res  : div_res;

    assign retire = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (capture) begin
            out_valid <= 1'b1;
        end else if (retire) begin
            out_valid <= 1'b0;
        end
    end

    // held through any number of stall cycles
    always_ff @(posedge clk) begin
        if (capture) begin
            res_q <= sel_res;
        end
    end

    assign hi = res_q.hi;
    assign lo = res_q.lo;

endmodule

`default_nettype wire

//--- source/md_divider.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module md_divider (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire md_op_pkg::md_req_t   req,
    output logic                      done,
    output md_op_pkg::md_res_t        res
);

    localparam int CNT_W = $clog2(`XLEN);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`XLEN - 1);

    md_ctrl_pkg::div_state_e state_q;
    md_ctrl_pkg::div_state_e state_d;

    logic [CNT_W-1:0]   cnt_q;
    logic               is_signed;
    logic [`XLEN-1:0]   dvd_abs;
    logic [`XLEN-1:0]   dvs_abs;
    logic [`XLEN-1:0]   dvsr_q;
    logic [`XLEN-1:0]   quo_q;
    logic [`XLEN-1:0]   rem_q;
    logic               neg_q;
    logic               neg_r;
    logic [`XLEN:0]     shifted;
    logic [`XLEN:0]     diff;
    logic               fits;
    logic               stepping;

    assign is_signed = (req.op == md_op_pkg::OP_DIV);

    // magnitudes for a signed divide, raw operands otherwise
    assign dvd_abs = (is_signed && req.src1[`XLEN-1]) ? -req.src1 : req.src1;
    assign dvs_abs = (is_signed && req.src2[`XLEN-1]) ? -req.src2 : req.src2;

    // a restoring step brings down the next dividend bit and tries the subtract
    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};
    assign fits    = ~diff[`XLEN];

    // the first of the 32 steps runs in DIV_LOAD, the rest in DIV_ITER
    assign stepping = (state_q == md_ctrl_pkg::DIV_LOAD) ||
                      (state_q == md_ctrl_pkg::DIV_ITER);

    always_comb begin
        state_d = state_q;
        case (state_q)
            md_ctrl_pkg::DIV_IDLE: begin
                if (start) begin
                    state_d = md_ctrl_pkg::DIV_LOAD;
                end
            end
            md_ctrl_pkg::DIV_LOAD: state_d = md_ctrl_pkg::DIV_ITER;
            md_ctrl_pkg::DIV_ITER: begin
                if (cnt_q == LAST_STEP) begin
                    state_d = md_ctrl_pkg::DIV_FIX;
                end
            end
            md_ctrl_pkg::DIV_FIX:  state_d = md_ctrl_pkg::DIV_DONE;
            default:               state_d = md_ctrl_pkg::DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= md_ctrl_pkg::DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == md_ctrl_pkg::DIV_IDLE) begin
                cnt_q <= '0;
            end else if (stepping) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == md_ctrl_pkg::DIV_IDLE && start) begin
            quo_q  <= dvd_abs;
            dvsr_q <= dvs_abs;
            rem_q  <= '0;
            neg_q  <= is_signed && (req.src1[`XLEN-1] ^ req.src2[`XLEN-1]);
            neg_r  <= is_signed && req.src1[`XLEN-1];
        end else if (stepping) begin
            rem_q <= fits ? diff[`XLEN-1:0] : shifted[`XLEN-1:0];
            quo_q <= {quo_q[`XLEN-2:0], fits};
        end
    end

    // remainder follows the dividend, quotient rounds toward zero
    always_ff @(posedge clk) begin
        if (state_q == md_ctrl_pkg::DIV_FIX) begin
            res.lo <= neg_q ? -quo_q : quo_q;
            res.hi <= neg_r ? -rem_q : rem_q;
        end
    end

    assign done = (state_q == md_ctrl_pkg::DIV_DONE);

endmodule

`default_nettype wire

//--- source/md_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module md_multiplier (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 start,
    input  wire md_op_pkg::md_req_t   req,
    output logic                      done,
    output md_op_pkg::md_res_t        res
);

    logic                      is_signed;
    logic signed [`XLEN:0]     a_ext;
    logic signed [`XLEN:0]     b_ext;
    logic signed [2*`XLEN+1:0] prod_full;
    logic [2*`XLEN-1:0]        prod_q;
    logic                      stage1_valid;

    assign is_signed = (req.op == md_op_pkg::OP_MULT);

    // one extra bit lets a single signed multiply cover both flavours
    assign a_ext = {is_signed & req.src1[`XLEN-1], req.src1};
    assign b_ext = {is_signed & req.src2[`XLEN-1], req.src2};

    assign prod_full = a_ext * b_ext;

    // stage one
    always_ff @(posedge clk) begin
        prod_q <= prod_full[2*`XLEN-1:0];
    end

    // stage two
    always_ff @(posedge clk) begin
        res.hi <= prod_q[2*`XLEN-1:`XLEN];
        res.lo <= prod_q[`XLEN-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1_valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            stage1_valid <= start;
            done         <= stage1_valid;
        end
    end

endmodule

`default_nettype wire

//--- source/md_issue.sv
`timescale 1ns/10ps
`default_nettype none

`include "muldiv_macros.svh"

module md_issue (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 in_valid,
    input  wire logic [5:0]           funct,
    input  wire logic [`XLEN-1:0]     src1,
    input  wire logic [`XLEN-1:0]     src2,
    input  wire logic                 retire,
    output logic                      busy,
    output logic                      mul_start,
    output logic                      div_start,
    output md_op_pkg::md_req_t        req,
    output md_ctrl_pkg::md_src_e      src
);

    logic [3:0]           hit;
    logic                 legal;
    logic                 accept;
    logic                 is_div;
    md_op_pkg::md_op_e    dec_op;

    // one-hot match against the four supported codes
    assign hit[0] = (funct == `FUNCT_MULT);
    assign hit[1] = (funct == `FUNCT_MULTU);
    assign hit[2] = (funct == `FUNCT_DIV);
    assign hit[3] = (funct == `FUNCT_DIVU);

    assign legal  = |hit;
    assign is_div = hit[2] | hit[3];

    // strobes during busy are dropped, not queued
    assign accept = in_valid && !busy && legal;

    always_comb begin
        case (hit)
            4'b0010: dec_op = md_op_pkg::OP_MULTU;
            4'b0100: dec_op = md_op_pkg::OP_DIV;
            4'b1000: dec_op = md_op_pkg::OP_DIVU;
            default: dec_op = md_op_pkg::OP_MULT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            src       <= md_ctrl_pkg::SRC_MUL;
        end else begin
            mul_start <= accept && !is_div;
            div_start <= accept && is_div;
            if (accept) begin
                busy <= 1'b1;
                src  <= is_div ? md_ctrl_pkg::SRC_DIV : md_ctrl_pkg::SRC_MUL;
            end else if (retire) begin
                busy <= 1'b0;
            end
        end
    end

    // request stays put until the next accepted strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            req.op   <= dec_op;
            req.src1 <= src1;
            req.src2 <= src2;
        end
    end

endmodule

`default_nettype wire

//--- source/md_ctrl_pkg.sv
`default_nettype none

package md_ctrl_pkg;

    // divider sequencing
    typedef enum logic [2:0] {
        DIV_IDLE = 3'd0,
        DIV_LOAD = 3'd1,
        DIV_ITER = 3'd2,
        DIV_FIX  = 3'd3,
        DIV_DONE = 3'd4
    } div_state_e;

    // unit that will deliver the pending result
    typedef enum logic {
        SRC_MUL = 1'b0,
        SRC_DIV = 1'b1
    } md_src_e;

endpackage

`default_nettype wire

//--- source/md_op_pkg.sv
`default_nettype none

`include "muldiv_macros.svh"

package md_op_pkg;

    // decoded operation, one code per funct
    typedef enum logic [1:0] {
        OP_MULT  = 2'd0,
        OP_MULTU = 2'd1,
        OP_DIV   = 2'd2,
        OP_DIVU  = 2'd3
    } md_op_e;

    // request handed to the multiplier or the divider
    // src1 is the dividend and src2 the divisor for a divide
    typedef struct packed {
        md_op_e            op;
        logic [`XLEN-1:0]  src1;
        logic [`XLEN-1:0]  src2;
    } md_req_t;

    // hi holds the upper product half or the remainder,
    // lo holds the lower product half or the quotient
    typedef struct packed {
        logic [`XLEN-1:0]  hi;
        logic [`XLEN-1:0]  lo;
    } md_res_t;

endpackage

`default_nettype wire

//--- include/muldiv_macros.svh
`ifndef MULDIV_MACROS_SVH
`define MULDIV_MACROS_SVH

// operand width of the integer datapath
`define XLEN 32

// funct field codes of the SPECIAL opcode group
`define FUNCT_MULT  6'h18
`define FUNCT_MULTU 6'h19
`define FUNCT_DIV   6'h1A
`define FUNCT_DIVU  6'h1B

`endif
